/* ray_quadric.f */
+incdir+bench
rtl/ray_quadric_pkg.sv
rtl/dot3_signed.sv
rtl/quadric_coeffs.sv
rtl/discriminant.sv
rtl/result_queue.sv
rtl/ray_quadric.sv
bench/ray_quadric_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ray_quadric testbench with Verilator, run from the project root

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f ray_quadric.f \
        --top-module ray_quadric_tb -Mdir obj_dir -o ray_quadric_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ray_quadric_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Testbench failed" "$log"; then
    echo "simulation reported a failure, see $log"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

exit 0

/* bench/tb_checks.svh */
`ifndef tb_checks_svh
`define tb_checks_svh

// included inside ray_quadric_tb, uses its coef_w and disc_w

// print the reason, then stop the run
task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
endtask

// a2, b and c2 share one width
task automatic check_coef(
    input string                     what,
    input logic signed [coef_w-1:0]  expv,
    input logic signed [coef_w-1:0]  actv
);
    if (actv !== expv) begin
        fail_run($sformatf("FAILED %s expected %0d actual %0d", what, expv, actv));
    end
endtask

// discriminant, wide enough for b*b
task automatic check_disc(
    input string                     what,
    input logic signed [disc_w-1:0]  expv,
    input logic signed [disc_w-1:0]  actv
);
    if (actv !== expv) begin
        fail_run($sformatf("FAILED %s expected %0d actual %0d", what, expv, actv));
    end
endtask

// single flags: hit, out_valid
task automatic check_bit(input string what, input logic expv, input logic actv);
    if (actv !== expv) begin
        fail_run($sformatf("FAILED %s expected %b actual %b", what, expv, actv));
    end
endtask

// event counts seen by the bench (results, credit pulses)
task automatic check_count(input string what, input int expv, input int actv);
    if (actv != expv) begin
        fail_run($sformatf("FAILED %s expected %0d actual %0d", what, expv, actv));
    end
endtask

`endif

/* bench/ray_quadric_tb.sv */
module ray_quadric_tb
    import ray_quadric_pkg::*;
();

    localparam int coord_w     = default_coord_w;
    localparam int frac        = default_frac;
    localparam int queue_depth = 4;
    localparam int out_credits = 2;
    localparam int coef_w      = 2 * coord_w + 3;
    localparam int disc_w      = 2 * coef_w + 1;
    localparam int unit        = 1 << frac;   // 1.0 in coordinate format
    localparam int clk_period  = 40;
    localparam int rays_total  = 2 + 4 + 2 + queue_depth + queue_depth;
    localparam longint wd_limit = longint'(rays_total + 20) * clk_period * 4;

    typedef struct {
        logic signed [coef_w-1:0] a2;
        logic signed [coef_w-1:0] b;
        logic signed [coef_w-1:0] c2;
        logic signed [disc_w-1:0] disc;
        logic                     hit;
    } result_t;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    logic [shape_w-1:0] shape;
    logic signed [coord_w-1:0] src_x, src_y, src_z;
    logic signed [coord_w-1:0] dir_x, dir_y, dir_z;
    logic out_credit = 1'b0;      // owned by the receiver process
    logic in_credit;
    logic out_valid;
    logic signed [coef_w-1:0] out_a2, out_b, out_c2;
    logic signed [disc_w-1:0] out_disc;
    logic out_hit;

    result_t     exp_q[$];               // expected results in input order
    int          tx_credits = queue_depth; // sender side credit count
    int          delivered = 0;          // results seen by the monitor
    int          in_credit_seen = 0;
    int          returned = 0;           // credits handed back by the receiver
    logic        return_credits = 1'b1;  // receiver hands credits back
    string       cur_test = "reset";
    logic [31:0] rng_state = 32'h80ca02e6;

    `include "tb_checks.svh"

    ray_quadric #(
        .coord_w(coord_w), .frac(frac), .queue_depth(queue_depth), .out_credits(out_credits)
    ) DUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .shape(shape),
        .src_x(src_x), .src_y(src_y), .src_z(src_z),
        .dir_x(dir_x), .dir_y(dir_y), .dir_z(dir_z),
        .out_credit(out_credit), .in_credit(in_credit), .out_valid(out_valid),
        .out_a2(out_a2), .out_b(out_b), .out_c2(out_c2),
        .out_disc(out_disc), .out_hit(out_hit)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(wd_limit);
        fail_run("watchdog expired, results stopped arriving from the DUT");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_coord();
        logic [31:0] r;
        r = next_rand();
        return int'($signed(r[coord_w-1:0])); // full signed coordinate range
    endfunction

    function automatic result_t make_result(input longint a2_v, b_v, c2_v, disc_v,
                                            input logic hit_v);
        result_t r;
        r.a2   = a2_v[coef_w-1:0];
        r.b    = b_v[coef_w-1:0];
        r.c2   = c2_v[coef_w-1:0];
        r.disc = disc_v[disc_w-1:0];
        r.hit  = hit_v;
        return r;
    endfunction

    // quadric rules as weights for the xy lanes and the z lane in exact 64-bit math
    function automatic result_t model_ray(input logic [shape_w-1:0] shp,
                                          input longint sx, sy, sz, dx, dy, dz);
        longint one_l, wxy, wz, minus;
        longint a2_v, b_v, c2_v, disc_v;
        one_l = longint'(1) << (2 * frac);
        wxy   = (shp == shape_off) ? 0 : 1;   // off zeroes every lane
        minus = (shp == shape_cone) ? 0 : 1;  // cone has no radius term
        case (shp)
            shape_sphere: wz = 1;
            shape_cone:   wz = -1;
            default:      wz = 0;              // cylinder and off both drop z
        endcase
        a2_v   = 2 * (wxy * (dx * dx + dy * dy) + wz * dz * dz);
        b_v    = 2 * (wxy * (dx * sx + dy * sy) + wz * dz * sz);
        c2_v   = 2 * (wxy * (sx * sx + sy * sy) + wz * sz * sz - minus * one_l);
        disc_v = b_v * b_v - a2_v * c2_v;
        return make_result(a2_v, b_v, c2_v, disc_v, (shp != shape_off) && (disc_v >= 0));
    endfunction

    // one ray per call and back to back when called in a row
    task automatic send_expect(input logic [shape_w-1:0] shp, input int sx, sy, sz,
                               input int dx, dy, dz, input result_t e);
        @(posedge clk);
        while (tx_credits == 0) begin
            in_valid <= 1'b0;       // idle a cycle without credit
            @(posedge clk);
        end
        in_valid <= 1'b1;
        shape    <= shp;
        src_x    <= coord_w'(sx);
        src_y    <= coord_w'(sy);
        src_z    <= coord_w'(sz);
        dir_x    <= coord_w'(dx);
        dir_y    <= coord_w'(dy);
        dir_z    <= coord_w'(dz);
        tx_credits--;
        exp_q.push_back(e);
    endtask

    task automatic send_ray(input logic [shape_w-1:0] shp, input int sx, sy, sz,
                            input int dx, dy, dz);
        send_expect(shp, sx, sy, sz, dx, dy, dz, model_ray(shp, sx, sy, sz, dx, dy, dz));
    endtask

    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // out_credit lands 2 cycles after the last result and in_credit after 1
    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    // result checker and credit bookkeeping on the falling edge
    always @(negedge clk) begin : monitor
        result_t e;
        if (rst_n) begin
            if (in_credit) begin
                tx_credits++;
                in_credit_seen++;
                if (tx_credits > queue_depth) fail_run("in_credit returned more than was spent");
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("a result appeared with no ray outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_coef({cur_test, " a2"}, e.a2, out_a2);
                    check_coef({cur_test, " b"}, e.b, out_b);
                    check_coef({cur_test, " c2"}, e.c2, out_c2);
                    check_disc({cur_test, " disc"}, e.disc, out_disc);
                    check_bit({cur_test, " hit"}, e.hit, out_hit);
                    delivered++;
                end
            end
        end
    end

    // receiver hands back one credit per consumed result
    always @(posedge clk) begin
        if (rst_n && return_credits && (returned < delivered)) begin
            out_credit <= 1'b1;
            returned++;
        end else begin
            out_credit <= 1'b0;
        end
    end

    task automatic test_sphere();
        cur_test = "test_sphere";
        // S=(0,0,-3) D=(0,0,1) gives a2=2 b=-6 c2=2*(9-1) disc=36-32
        send_expect(shape_sphere, 0, 0, -3 * unit, 0, 0, unit,
                    make_result(2 * 65536, -6 * 65536, 16 * 65536, 4 * (longint'(1) << 32), 1));
        // S=(0,3,-3) gives c2=2*(18-1) and disc=36-68 so it misses
        send_expect(shape_sphere, 0, 3 * unit, -3 * unit, 0, 0, unit,
                    make_result(2 * 65536, -6 * 65536, 34 * 65536, -32 * (longint'(1) << 32), 0));
        end_burst();
        wait_drain();
    endtask

    task automatic test_cylinder_cone();
        logic [shape_w-1:0] shp;
        cur_test = "test_cylinder_cone";
        for (int i = 0; i < 2; i++) begin
            shp = (i == 0) ? shape_cylinder : shape_cone;
            send_ray(shp, 0, 0, -3 * unit, 0, 0, unit);
            send_ray(shp, 0, 3 * unit, -3 * unit, 0, 0, unit);
        end
        end_burst();
        wait_drain();
    endtask

    task automatic test_off();
        result_t e;
        cur_test = "test_off";
        e = make_result(0, 0, -2 * (longint'(1) << (2 * frac)), 0, 0);
        send_expect(shape_off, unit, -2 * unit, 3 * unit, -unit, unit / 2, 5, e);
        send_expect(shape_off, 0, 0, -3 * unit, 0, 0, unit, e); // the sphere hit ray turned off
        end_burst();
        wait_drain();
    endtask

    task automatic send_random_rays(input int n);
        int c[6];
        logic [shape_w-1:0] shp;
        for (int i = 0; i < n; i++) begin
            shp = next_rand() % 4;  // mixed shapes including off
            foreach (c[k]) c[k] = rand_coord();
            send_ray(shp, c[0], c[1], c[2], c[3], c[4], c[5]);
        end
        end_burst();
    endtask

    task automatic test_burst();
        cur_test = "test_burst";
        send_random_rays(queue_depth);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int base_deliv;
        int base_cred;
        cur_test = "test_backpressure";
        @(negedge clk);
        return_credits = 1'b0;      // receiver holds its credits
        base_deliv = delivered;
        base_cred  = in_credit_seen;
        send_random_rays(queue_depth);
        while (delivered - base_deliv < out_credits) @(posedge clk);
        repeat (30) begin
            @(negedge clk);
            check_bit("test_backpressure out_valid while credit withheld", 1'b0, out_valid);
        end
        @(posedge clk);
        check_count("test_backpressure in_credit before release", out_credits,
                    in_credit_seen - base_cred);
        @(negedge clk);
        return_credits = 1'b1;
        wait_drain();
        check_count("test_backpressure in_credit", queue_depth, in_credit_seen - base_cred);
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        shape    = shape_off;
        src_x    = '0;
        src_y    = '0;
        src_z    = '0;
        dir_x    = '0;
        dir_y    = '0;
        dir_z    = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_sphere();
        test_cylinder_cone();
        test_off();
        test_burst();
        test_backpressure();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* rtl/ray_quadric.sv */
module ray_quadric
    import ray_quadric_pkg::*;
#(
    parameter int coord_w     = default_coord_w,
    parameter int frac        = default_frac,
    parameter int queue_depth = 4,
    parameter int out_credits = 2
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [shape_w-1:0]           shape,
    input  logic signed [coord_w-1:0]    src_x,
    input  logic signed [coord_w-1:0]    src_y,
    input  logic signed [coord_w-1:0]    src_z,
    input  logic signed [coord_w-1:0]    dir_x,
    input  logic signed [coord_w-1:0]    dir_y,
    input  logic signed [coord_w-1:0]    dir_z,
    input  logic                         out_credit,
    output logic                         in_credit,
    output logic                         out_valid,
    output logic signed [2*coord_w+2:0]  out_a2,
    output logic signed [2*coord_w+2:0]  out_b,
    output logic signed [2*coord_w+2:0]  out_c2,
    output logic signed [4*coord_w+6:0]  out_disc,
    output logic                         out_hit
);

    localparam int coef_w = 2 * coord_w + 3;
    localparam int disc_w = 2 * coef_w + 1;

    // coefficient stage to discriminant stage
    logic                     coef_valid;
    logic                     coef_off;
    logic signed [coef_w-1:0] coef_a2;
    logic signed [coef_w-1:0] coef_b;
    logic signed [coef_w-1:0] coef_c2;

    // discriminant stage to the queue
    logic                     res_valid;
    logic signed [coef_w-1:0] res_a2;
    logic signed [coef_w-1:0] res_b;
    logic signed [coef_w-1:0] res_c2;
    logic signed [disc_w-1:0] res_disc;
    logic                     res_hit;

    quadric_coeffs #(.coord_w(coord_w), .frac(frac)) u_coeffs (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .shape(shape),
        .src_x(src_x), .src_y(src_y), .src_z(src_z),
        .dir_x(dir_x), .dir_y(dir_y), .dir_z(dir_z),
        .out_valid(coef_valid), .shape_off_q(coef_off),
        .a2(coef_a2), .b(coef_b), .c2(coef_c2)
    );

    discriminant #(.coord_w(coord_w)) u_disc (
        .clk(clk), .rst_n(rst_n), .in_valid(coef_valid), .shape_off_q(coef_off),
        .a2(coef_a2), .b(coef_b), .c2(coef_c2),
        .out_valid(res_valid), .out_a2(res_a2), .out_b(res_b), .out_c2(res_c2),
        .disc(res_disc), .hit(res_hit)
    );

    // slot reserved on in_valid, so the pipeline itself never stalls
    result_queue #(
        .coord_w(coord_w),
        .queue_depth(queue_depth),
        .out_credits(out_credits)
    ) u_queue (
        .clk(clk), .rst_n(rst_n), .reserve(in_valid),
        .wr_valid(res_valid), .wr_a2(res_a2), .wr_b(res_b), .wr_c2(res_c2),
        .wr_disc(res_disc), .wr_hit(res_hit), .out_credit(out_credit),
        .in_credit(in_credit), .out_valid(out_valid),
        .out_a2(out_a2), .out_b(out_b), .out_c2(out_c2),
        .out_disc(out_disc), .out_hit(out_hit)
    );

endmodule

/* rtl/result_queue.sv */
module result_queue
    import ray_quadric_pkg::*;
#(
    parameter int coord_w     = default_coord_w,
    parameter int queue_depth = 4,
    parameter int out_credits = 2
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         reserve,    // a ray entered the pipeline
    input  logic                         wr_valid,
    input  logic signed [2*coord_w+2:0]  wr_a2,
    input  logic signed [2*coord_w+2:0]  wr_b,
    input  logic signed [2*coord_w+2:0]  wr_c2,
    input  logic signed [4*coord_w+6:0]  wr_disc,
    input  logic                         wr_hit,
    input  logic                         out_credit, // receiver frees one slot
    output logic                         in_credit,
    output logic                         out_valid,
    output logic signed [2*coord_w+2:0]  out_a2,
    output logic signed [2*coord_w+2:0]  out_b,
    output logic signed [2*coord_w+2:0]  out_c2,
    output logic signed [4*coord_w+6:0]  out_disc,
    output logic                         out_hit
);

    localparam int coef_w = 2 * coord_w + 3;
    localparam int disc_w = 2 * coef_w + 1;
    localparam int ptr_w  = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w  = $clog2(queue_depth + 1);
    localparam int cred_w = $clog2(out_credits + 1);

    logic signed [coef_w-1:0] mem_a2   [queue_depth];
    logic signed [coef_w-1:0] mem_b    [queue_depth];
    logic signed [coef_w-1:0] mem_c2   [queue_depth];
    logic signed [disc_w-1:0] mem_disc [queue_depth];
    logic                     mem_hit  [queue_depth];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;       // results sitting in the queue
    logic [cnt_w-1:0]  outstanding; // reserved slots, pipeline plus queue
    logic [cred_w-1:0] credit_cnt;  // receiver slots we may still fill

    // wrap at queue_depth, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // pop whenever something is held and the receiver has room
    assign out_valid = (count != '0) && (credit_cnt != '0);

    assign out_a2   = mem_a2[rd_ptr];
    assign out_b    = mem_b[rd_ptr];
    assign out_c2   = mem_c2[rd_ptr];
    assign out_disc = mem_disc[rd_ptr];
    assign out_hit  = mem_hit[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem_a2[wr_ptr]   <= wr_a2;
            mem_b[wr_ptr]    <= wr_b;
            mem_c2[wr_ptr]   <= wr_c2;
            mem_disc[wr_ptr] <= wr_disc;
            mem_hit[wr_ptr]  <= wr_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            outstanding <= '0;
            credit_cnt  <= cred_w'(out_credits);
            in_credit   <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (out_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count       <= count + cnt_w'(wr_valid) - cnt_w'(out_valid);
            outstanding <= outstanding + cnt_w'(reserve) - cnt_w'(out_valid);
            credit_cnt  <= credit_cnt + cred_w'(out_credit) - cred_w'(out_valid);
            in_credit   <= out_valid; // slot freed, sender gets it back
        end
    end

    // reservation at input time means a full queue is never written
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> count < cnt_w'(queue_depth));

    // sender must respect its credits
    a_outstanding_max: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= cnt_w'(queue_depth));

    // receiver must not return more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= cred_w'(out_credits));

endmodule

/* rtl/discriminant.sv */
module discriminant
    import ray_quadric_pkg::*;
#(
    parameter int coord_w = default_coord_w
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic                         shape_off_q,
    input  logic signed [2*coord_w+2:0]  a2,
    input  logic signed [2*coord_w+2:0]  b,
    input  logic signed [2*coord_w+2:0]  c2,
    output logic                         out_valid,
    output logic signed [2*coord_w+2:0]  out_a2,
    output logic signed [2*coord_w+2:0]  out_b,
    output logic signed [2*coord_w+2:0]  out_c2,
    output logic signed [4*coord_w+6:0]  disc,
    output logic                         hit
);

    localparam int coef_w = 2 * coord_w + 3;
    localparam int disc_w = 2 * coef_w + 1; // one bit over the products

    logic signed [2*coef_w-1:0] bb_q;       // b*b, always >= 0
    logic signed [2*coef_w-1:0] ac_q;       // (2a)*(2c) = 4ac
    logic signed [coef_w-1:0]   a2_q;
    logic signed [coef_w-1:0]   b_q;
    logic signed [coef_w-1:0]   c2_q;
    logic                       off_q;
    logic                       valid_q;
    logic signed [disc_w-1:0]   diff;

    // stage 1 registers both products while the coefficients ride along
    always_ff @(posedge clk) begin
        bb_q  <= b * b;
        ac_q  <= a2 * c2;
        a2_q  <= a2;
        b_q   <= b;
        c2_q  <= c2;
        off_q <= shape_off_q;
    end

    assign diff = disc_w'(bb_q) - disc_w'(ac_q); // exact with no overflow

    // stage 2 forms the difference and the hit decision
    always_ff @(posedge clk) begin
        disc   <= diff;
        hit    <= !off_q && !diff[disc_w-1]; // real roots and a real shape
        out_a2 <= a2_q;
        out_b  <= b_q;
        out_c2 <= c2_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

endmodule

/* rtl/quadric_coeffs.sv */
module quadric_coeffs
    import ray_quadric_pkg::*;
#(
    parameter int coord_w = default_coord_w,
    parameter int frac    = default_frac
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [shape_w-1:0]           shape,
    input  logic signed [coord_w-1:0]    src_x,
    input  logic signed [coord_w-1:0]    src_y,
    input  logic signed [coord_w-1:0]    src_z,
    input  logic signed [coord_w-1:0]    dir_x,
    input  logic signed [coord_w-1:0]    dir_y,
    input  logic signed [coord_w-1:0]    dir_z,
    output logic                         out_valid,
    output logic                         shape_off_q, // off rays must not hit later
    output logic signed [2*coord_w+2:0]  a2,
    output logic signed [2*coord_w+2:0]  b,
    output logic signed [2*coord_w+2:0]  c2
);

    localparam int dot_w  = 2 * coord_w + 2;
    localparam int coef_w = 2 * coord_w + 3;
    // 1.0 at product scale since the products hold 2*frac fraction bits
    localparam logic signed [coef_w-1:0] one = coef_w'(1) << (2 * frac);

    logic signed [coord_w-1:0] sx_m;
    logic signed [coord_w-1:0] sy_m;
    logic signed [coord_w-1:0] sz_m;
    logic signed [coord_w-1:0] dx_m;
    logic signed [coord_w-1:0] dy_m;
    logic signed [coord_w-1:0] dz_m;
    logic                      neg_z;
    logic                      minus_one;    // c2 keeps the -1 term
    logic                      is_off;

    logic signed [dot_w-1:0]   dd_sum;       // D.D
    logic signed [dot_w-1:0]   ds_sum;       // D.S
    logic signed [dot_w-1:0]   ss_sum;       // S.S
    logic                      dd_valid;
    logic                      ds_valid;
    logic                      ss_valid;
    logic [dot_stages-1:0]     minus_one_q;  // flags wait for the dot units
    logic [dot_stages-1:0]     off_q;
    logic signed [coef_w-1:0]  c_diff;

    // lane masking by shape
    always_comb begin
        sx_m      = src_x;
        sy_m      = src_y;
        sz_m      = src_z;
        dx_m      = dir_x;
        dy_m      = dir_y;
        dz_m      = dir_z;
        neg_z     = 1'b0;
        minus_one = 1'b1;
        case (shape)
            shape_off: begin   // everything zeroed and only -1 survives
                sx_m = '0;
                sy_m = '0;
                sz_m = '0;
                dx_m = '0;
                dy_m = '0;
                dz_m = '0;
            end
            shape_cylinder: begin
                sz_m = '0;     // infinite along z
                dz_m = '0;
            end
            shape_cone: begin
                neg_z     = 1'b1;
                minus_one = 1'b0; // apex at origin so no radius term
            end
            default: begin
                // sphere keeps all three lanes
            end
        endcase
    end

    assign is_off = (shape == shape_off);

    dot3_signed #(.coord_w(coord_w)) u_dd (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .a_x(dx_m), .a_y(dy_m), .a_z(dz_m),
        .b_x(dx_m), .b_y(dy_m), .b_z(dz_m),
        .neg_z(neg_z), .out_valid(dd_valid), .sum(dd_sum)
    );

    dot3_signed #(.coord_w(coord_w)) u_ds (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .a_x(dx_m), .a_y(dy_m), .a_z(dz_m),
        .b_x(sx_m), .b_y(sy_m), .b_z(sz_m),
        .neg_z(neg_z), .out_valid(ds_valid), .sum(ds_sum)
    );

    dot3_signed #(.coord_w(coord_w)) u_ss (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .a_x(sx_m), .a_y(sy_m), .a_z(sz_m),
        .b_x(sx_m), .b_y(sy_m), .b_z(sz_m),
        .neg_z(neg_z), .out_valid(ss_valid), .sum(ss_sum)
    );

    always_ff @(posedge clk) begin
        minus_one_q <= {minus_one_q[dot_stages-2:0], minus_one};
        off_q       <= {off_q[dot_stages-2:0], is_off};
    end

    always_comb begin
        c_diff = coef_w'(ss_sum);
        if (minus_one_q[dot_stages-1]) begin
            c_diff = c_diff - one;
        end
    end

    // stage 3 doubles the coefficients
    always_ff @(posedge clk) begin
        a2          <= coef_w'(dd_sum) <<< 1;
        b           <= coef_w'(ds_sum) <<< 1;
        c2          <= c_diff <<< 1;
        shape_off_q <= off_q[dot_stages-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dd_valid & ds_valid & ss_valid; // all three march together
        end
    end

endmodule

/* rtl/dot3_signed.sv */
module dot3_signed
    import ray_quadric_pkg::*;
#(
    parameter int coord_w = default_coord_w
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic signed [coord_w-1:0]    a_x,
    input  logic signed [coord_w-1:0]    a_y,
    input  logic signed [coord_w-1:0]    a_z,
    input  logic signed [coord_w-1:0]    b_x,
    input  logic signed [coord_w-1:0]    b_y,
    input  logic signed [coord_w-1:0]    b_z,
    input  logic                         neg_z,     // cone: z lane counts negative
    output logic                         out_valid,
    output logic signed [2*coord_w+1:0]  sum
);

    localparam int prod_w = 2 * coord_w;     // full product, nothing rounded off
    localparam int sum_w  = 2 * coord_w + 2; // headroom for three lanes

    logic signed [prod_w-1:0] prod_x_q;
    logic signed [prod_w-1:0] prod_y_q;
    logic signed [prod_w-1:0] prod_z_q;
    logic                     neg_z_q;       // sign flag follows its product
    logic [dot_stages-1:0]    valid_q;       // valid shift, one bit per stage

    // stage 1: per-lane products
    always_ff @(posedge clk) begin
        prod_x_q <= a_x * b_x;
        prod_y_q <= a_y * b_y;
        prod_z_q <= a_z * b_z;
        neg_z_q  <= neg_z;
    end

    // stage 2: sign-extend and add, z subtracted when flagged
    always_ff @(posedge clk) begin
        if (neg_z_q) begin
            sum <= sum_w'(prod_x_q) + sum_w'(prod_y_q) - sum_w'(prod_z_q);
        end else begin
            sum <= sum_w'(prod_x_q) + sum_w'(prod_y_q) + sum_w'(prod_z_q);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[dot_stages-2:0], in_valid};
        end
    end

    assign out_valid = valid_q[dot_stages-1]; // lines up with sum

endmodule

/* rtl/ray_quadric_pkg.sv */
package ray_quadric_pkg;

    // shape selector, one code per quadric
    localparam int shape_w = 2;

    localparam logic [shape_w-1:0] shape_off      = 2'd0; // no surface, never hits
    localparam logic [shape_w-1:0] shape_sphere   = 2'd1; // x^2 + y^2 + z^2 = 1
    localparam logic [shape_w-1:0] shape_cylinder = 2'd2; // x^2 + y^2 = 1, open in z
    localparam logic [shape_w-1:0] shape_cone     = 2'd3; // x^2 + y^2 = z^2

    // pipeline latencies in clock cycles
    localparam int dot_stages  = 2; // lane products, then the sum
    localparam int coef_stages = 3; // dot units plus the doubling stage
    localparam int disc_stages = 2; // squares, then the difference

    // default coordinate format, signed fixed point
    localparam int default_coord_w = 12;
    localparam int default_frac    = 8;  // products carry twice this

endpackage
